// ==== logic/rvc_pkg.sv ====
package rvc_pkg;

  localparam logic [31:0] PC_RESET  = 32'h0000_0000;  // Pc of the first parcel
  localparam logic [1:0]  QUAD_FULL = 2'b11;          // Low bits of a 32-bit instruction
  localparam logic [4:0]  REG_RA    = 5'd1;           // Return address, x1

  // RV32I major opcodes that this front end produces or accepts
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_IMM    = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic {
    ALIGN_EMPTY = 1'b0,  // Nothing held
    ALIGN_HALF  = 1'b1   // Lower half of a 32-bit instruction held
  } align_state_e;

  // Aligner to expander
  typedef struct packed {
    logic        valid;       // One-cycle strobe
    logic [31:0] pc;          // Pc of the first parcel
    logic [31:0] word;        // Upper half zero when compressed
    logic        compressed;
  } aligned_t;

  // Expander to decoder
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;       // Full RV32I word, zero when illegal
    logic        compressed;
    logic        illegal;
  } expanded_t;

  // Decoder output
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    logic        illegal;
    opcode_e     op;          // Zero when illegal
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;         // Sign-extended, format picked by op
  } decoded_t;

endpackage

// ==== logic/parcel_aligner.sv ====
module parcel_aligner (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              parcel_valid,
  input  logic [15:0]       parcel,
  output rvc_pkg::aligned_t aligned
);

  rvc_pkg::align_state_e state;
  logic [31:0] next_pc;       // Pc of the next parcel
  logic [15:0] low_half;      // Held lower half
  logic [31:0] low_pc;        // Pc of the held half
  logic        is_full_low;   // Parcel opens a 32-bit instruction
  logic        complete;      // Parcel finishes an instruction
  logic        valid_q;
  logic [31:0] pc_q;
  logic [31:0] word_q;
  logic        compressed_q;

  assign is_full_low = (parcel[1:0] == rvc_pkg::QUAD_FULL);
  assign complete    = parcel_valid && (state == rvc_pkg::ALIGN_HALF || !is_full_low);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= rvc_pkg::ALIGN_EMPTY;  // Drops any held half
      next_pc <= rvc_pkg::PC_RESET;
      valid_q <= 1'b0;
    end else begin
      valid_q <= complete;
      if (parcel_valid) begin
        next_pc <= next_pc + 32'd2;
        if (state == rvc_pkg::ALIGN_EMPTY && is_full_low) state <= rvc_pkg::ALIGN_HALF;
        else state <= rvc_pkg::ALIGN_EMPTY;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (parcel_valid) begin
      if (state == rvc_pkg::ALIGN_HALF) begin
        pc_q         <= low_pc;  // Full word carries pc of its lower half
        word_q       <= {parcel, low_half};
        compressed_q <= 1'b0;
      end else begin
        low_half     <= parcel;
        low_pc       <= next_pc;
        pc_q         <= next_pc;
        word_q       <= {16'h0000, parcel};
        compressed_q <= !is_full_low;
      end
    end
  end

  assign aligned = '{valid: valid_q, pc: pc_q, word: word_q, compressed: compressed_q};

endmodule

// ==== logic/rvc_expander.sv ====
module rvc_expander (
  input  logic               clk,
  input  logic               arst_n,
  input  rvc_pkg::aligned_t  aligned,
  output rvc_pkg::expanded_t expanded
);

  logic [15:0] c;          // Compressed parcel
  logic [4:0]  rd_f;       // Full rd/rs1 field
  logic [4:0]  rs2_f;      // Full rs2 field
  logic [4:0]  rs1_p;      // Three-bit field mapped onto x8-x15
  logic [4:0]  rs2_p;
  logic [11:0] imm6;       // Sign-extended 6-bit immediate
  logic [6:0]  lsw_off;    // C.LW/C.SW offset scaled by 4
  logic [20:0] j_off;
  logic [12:0] b_off;
  logic [31:0] instr_d;
  logic        illegal_d;
  logic        valid_q;
  logic [31:0] pc_q;
  logic [31:0] instr_q;
  logic        compressed_q;
  logic        illegal_q;

  assign c       = aligned.word[15:0];
  assign rd_f    = c[11:7];
  assign rs2_f   = c[6:2];
  assign rs1_p   = {2'b01, c[9:7]};
  assign rs2_p   = {2'b01, c[4:2]};
  assign imm6    = {{6{c[12]}}, c[12], c[6:2]};
  assign lsw_off = {c[5], c[12:10], c[6], 2'b00};
  assign j_off   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  assign b_off   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

  always_comb begin
    instr_d   = '0;
    illegal_d = 1'b1;  // Anything not matched below
    if (!aligned.compressed) begin
      instr_d   = aligned.word;
      illegal_d = 1'b0;
    end else begin
      case (c[1:0])
        2'b00: begin
          case (c[15:13])
            3'b010: begin  // C.LW
              instr_d   = {5'b0, lsw_off, rs1_p, 3'b010, rs2_p, rvc_pkg::OPC_LOAD};
              illegal_d = 1'b0;
            end
            3'b110: begin  // C.SW
              instr_d   = {5'b0, lsw_off[6:5], rs2_p, rs1_p, 3'b010, lsw_off[4:0],
                           rvc_pkg::OPC_STORE};
              illegal_d = 1'b0;
            end
            default: ;
          endcase
        end
        2'b01: begin
          case (c[15:13])
            3'b000: begin  // C.ADDI
              instr_d   = {imm6, rd_f, 3'b000, rd_f, rvc_pkg::OPC_IMM};
              illegal_d = 1'b0;
            end
            3'b001, 3'b101: begin  // C.JAL links through ra, C.J through x0
              instr_d   = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                           c[15] ? 5'd0 : rvc_pkg::REG_RA, rvc_pkg::OPC_JAL};
              illegal_d = 1'b0;
            end
            3'b010: begin  // C.LI
              instr_d   = {imm6, 5'd0, 3'b000, rd_f, rvc_pkg::OPC_IMM};
              illegal_d = 1'b0;
            end
            3'b011: begin  // C.LUI; rd x2 is the stack form
              if (rd_f != 5'd2 && {c[12], c[6:2]} != 6'd0) begin
                instr_d   = {{14{c[12]}}, c[12], c[6:2], rd_f, rvc_pkg::OPC_LUI};
                illegal_d = 1'b0;
              end
            end
            3'b100: begin
              case (c[11:10])
                2'b00, 2'b01: begin  // C.SRLI, C.SRAI; shamt[5] reserved on RV32
                  if (!c[12]) begin
                    instr_d   = {1'b0, c[10], 5'b0, c[6:2], rs1_p, 3'b101, rs1_p,
                                 rvc_pkg::OPC_IMM};
                    illegal_d = 1'b0;
                  end
                end
                2'b10: begin  // C.ANDI
                  instr_d   = {imm6, rs1_p, 3'b111, rs1_p, rvc_pkg::OPC_IMM};
                  illegal_d = 1'b0;
                end
                default: begin  // Register-register ALU ops
                  if (!c[12]) begin
                    illegal_d = 1'b0;
                    case (c[6:5])
                      2'b00:   instr_d = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                          rvc_pkg::OPC_OP};
                      2'b01:   instr_d = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, rvc_pkg::OPC_OP};
                      2'b10:   instr_d = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, rvc_pkg::OPC_OP};
                      default: instr_d = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, rvc_pkg::OPC_OP};
                    endcase
                  end
                end
              endcase
            end
            default: begin  // C.BEQZ, C.BNEZ
              instr_d   = {b_off[12], b_off[10:5], 5'd0, rs1_p, 2'b00, c[13], b_off[4:1],
                           b_off[11], rvc_pkg::OPC_BRANCH};
              illegal_d = 1'b0;
            end
          endcase
        end
        2'b10: begin
          if (c[15:13] == 3'b000 && !c[12]) begin  // C.SLLI
            instr_d   = {7'b0, rs2_f, rd_f, 3'b001, rd_f, rvc_pkg::OPC_IMM};
            illegal_d = 1'b0;
          end else if (c[15:13] == 3'b100) begin
            if (rs2_f != 5'd0) begin  // C.MV adds x0, C.ADD adds rd
              instr_d   = {7'b0, rs2_f, c[12] ? rd_f : 5'd0, 3'b000, rd_f, rvc_pkg::OPC_OP};
              illegal_d = 1'b0;
            end else if (rd_f != 5'd0) begin  // C.JR, C.JALR
              instr_d   = {12'b0, rd_f, 3'b000, c[12] ? rvc_pkg::REG_RA : 5'd0,
                           rvc_pkg::OPC_JALR};
              illegal_d = 1'b0;
            end
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else valid_q <= aligned.valid;
  end

  always_ff @(posedge clk) begin
    if (aligned.valid) begin
      pc_q         <= aligned.pc;
      instr_q      <= instr_d;
      compressed_q <= aligned.compressed;
      illegal_q    <= illegal_d;
    end
  end

  assign expanded = '{valid: valid_q, pc: pc_q, instr: instr_q,
                      compressed: compressed_q, illegal: illegal_q};

endmodule

// ==== logic/instr_decoder.sv ====
module instr_decoder (
  input  logic               clk,
  input  logic               arst_n,
  input  rvc_pkg::expanded_t expanded,
  output rvc_pkg::decoded_t  out
);

  logic [31:0]      ins;
  logic             known;      // Opcode is one of opcode_e
  logic             illegal_d;
  logic [31:0]      imm_d;
  logic [31:0]      instr_d;
  rvc_pkg::opcode_e op_d;
  logic             valid_q;
  logic [31:0]      pc_q;
  logic [31:0]      instr_q;
  logic             compressed_q;
  logic             illegal_q;
  rvc_pkg::opcode_e op_q;
  logic [31:0]      imm_q;

  assign ins = expanded.instr;

  always_comb begin
    known = 1'b1;
    case (ins[6:0])
      rvc_pkg::OPC_LOAD, rvc_pkg::OPC_IMM, rvc_pkg::OPC_JALR:
        imm_d = {{20{ins[31]}}, ins[31:20]};                                  // I
      rvc_pkg::OPC_STORE:  imm_d = {{20{ins[31]}}, ins[31:25], ins[11:7]};   // S
      rvc_pkg::OPC_BRANCH:
        imm_d = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};  // B
      rvc_pkg::OPC_LUI:    imm_d = {ins[31:12], 12'b0};                      // U
      rvc_pkg::OPC_JAL:
        imm_d = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};  // J
      rvc_pkg::OPC_OP:     imm_d = '0;
      default: begin
        known = 1'b0;
        imm_d = '0;
      end
    endcase
    illegal_d = expanded.illegal || !known;
    // An illegal result leaves with every field cleared
    instr_d = illegal_d ? '0 : ins;
    op_d    = rvc_pkg::opcode_e'(instr_d[6:0]);
    if (illegal_d) imm_d = '0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else valid_q <= expanded.valid;
  end

  always_ff @(posedge clk) begin
    if (expanded.valid) begin
      pc_q         <= expanded.pc;
      instr_q      <= instr_d;
      compressed_q <= expanded.compressed;
      illegal_q    <= illegal_d;
      op_q         <= op_d;
      imm_q        <= imm_d;
    end
  end

  // Register fields sit at fixed positions in every format
  assign out = '{valid:      valid_q,
                 pc:         pc_q,
                 instr:      instr_q,
                 compressed: compressed_q,
                 illegal:    illegal_q,
                 op:         op_q,
                 rd:         instr_q[11:7],
                 rs1:        instr_q[19:15],
                 rs2:        instr_q[24:20],
                 funct3:     instr_q[14:12],
                 funct7:     instr_q[31:25],
                 imm:        imm_q};

endmodule

// ==== logic/rv_frontend.sv ====
module rv_frontend (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              parcel_valid,
  input  logic [15:0]       parcel,
  output rvc_pkg::decoded_t out
);

  rvc_pkg::aligned_t  aligned;   // Stage 1 result
  rvc_pkg::expanded_t expanded;  // Stage 2 result

  parcel_aligner u_aligner (
    .clk          (clk),
    .arst_n       (arst_n),
    .parcel_valid (parcel_valid),
    .parcel       (parcel),
    .aligned      (aligned)
  );

  rvc_expander u_expander (
    .clk      (clk),
    .arst_n   (arst_n),
    .aligned  (aligned),
    .expanded (expanded)
  );

  instr_decoder u_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .expanded (expanded),
    .out      (out)         // Three cycles after the completing parcel
  );

endmodule

// ==== tests/rv_frontend_tb.sv ====
module rv_frontend_tb;

  typedef struct {
    string       name;
    int          n;          // Parcels per instruction
    logic [15:0] p0;
    logic [15:0] p1;
    logic [31:0] instr;
    logic        illegal;
    logic [6:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
  } vec_t;

  typedef struct {
    vec_t        v;
    logic [31:0] pc;
    int          edge_n;     // Edge that sampled the last parcel
  } expect_t;

  logic              clk;
  logic              arst_n;
  logic              parcel_valid;
  logic [15:0]       parcel;
  rvc_pkg::decoded_t out;

  vec_t    vecs[$];
  expect_t expq[$];
  int      edge_count;
  int      parcel_count;        // Parcels accepted since reset
  int      value_errors;
  int      other_errors;
  int      sent_count;
  int      out_count;

  rv_frontend dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .parcel_valid (parcel_valid),
    .parcel       (parcel),
    .out          (out)
  );

  always #5 clk = ~clk;

  always @(posedge clk) edge_count++;

  task automatic add_vec(string name, int n, logic [15:0] p0, logic [15:0] p1,
                         logic [31:0] instr, logic illegal, logic [6:0] op, logic [4:0] rd,
                         logic [4:0] rs1, logic [4:0] rs2, logic [2:0] funct3,
                         logic [6:0] funct7, logic [31:0] imm);
    vecs.push_back('{name, n, p0, p1, instr, illegal, op, rd, rs1, rs2, funct3, funct7, imm});
  endtask

  task automatic build_table();
    add_vec("c_lw", 1, 16'h40C0, 16'h0, 32'h0044A403, 0, rvc_pkg::OPC_LOAD, 8, 9, 4,
            3'd2, 7'h00, 32'h4);
    add_vec("c_sw", 1, 16'hC588, 16'h0, 32'h00A5A423, 0, rvc_pkg::OPC_STORE, 8, 11, 10,
            3'd2, 7'h00, 32'h8);
    add_vec("c_addi_neg", 1, 16'h12F5, 16'h0, 32'hFFD28293, 0, rvc_pkg::OPC_IMM, 5, 5, 29,
            3'd0, 7'h7F, 32'hFFFFFFFD);
    add_vec("c_li", 1, 16'h457D, 16'h0, 32'h01F00513, 0, rvc_pkg::OPC_IMM, 10, 0, 31,
            3'd0, 7'h00, 32'h1F);
    add_vec("c_lui_neg", 1, 16'h73FD, 16'h0, 32'hFFFFF3B7, 0, rvc_pkg::OPC_LUI, 7, 31, 31,
            3'd7, 7'h7F, 32'hFFFFF000);
    add_vec("c_srli", 1, 16'h8091, 16'h0, 32'h0044D493, 0, rvc_pkg::OPC_IMM, 9, 9, 4,
            3'd5, 7'h00, 32'h4);
    add_vec("c_srai", 1, 16'h8405, 16'h0, 32'h40145413, 0, rvc_pkg::OPC_IMM, 8, 8, 1,
            3'd5, 7'h20, 32'h401);
    add_vec("c_andi_neg", 1, 16'h997D, 16'h0, 32'hFFF57513, 0, rvc_pkg::OPC_IMM, 10, 10, 31,
            3'd7, 7'h7F, 32'hFFFFFFFF);
    add_vec("c_sub", 1, 16'h8C05, 16'h0, 32'h40940433, 0, rvc_pkg::OPC_OP, 8, 8, 9,
            3'd0, 7'h20, 32'h0);
    add_vec("c_xor", 1, 16'h8E35, 16'h0, 32'h00D64633, 0, rvc_pkg::OPC_OP, 12, 12, 13,
            3'd4, 7'h00, 32'h0);
    add_vec("c_or", 1, 16'h8F5D, 16'h0, 32'h00F76733, 0, rvc_pkg::OPC_OP, 14, 14, 15,
            3'd6, 7'h00, 32'h0);
    add_vec("c_and", 1, 16'h8C7D, 16'h0, 32'h00F47433, 0, rvc_pkg::OPC_OP, 8, 8, 15,
            3'd7, 7'h00, 32'h0);
    add_vec("c_j_neg", 1, 16'hBFFD, 16'h0, 32'hFFFFF06F, 0, rvc_pkg::OPC_JAL, 0, 31, 31,
            3'd7, 7'h7F, 32'hFFFFFFFE);
    add_vec("c_jal", 1, 16'h2021, 16'h0, 32'h008000EF, 0, rvc_pkg::OPC_JAL, 1, 0, 8,
            3'd0, 7'h00, 32'h8);
    add_vec("c_beqz_neg", 1, 16'hDC75, 16'h0, 32'hFE040EE3, 0, rvc_pkg::OPC_BRANCH, 29, 8, 0,
            3'd0, 7'h7F, 32'hFFFFFFFC);
    add_vec("c_bnez", 1, 16'hE099, 16'h0, 32'h00049363, 0, rvc_pkg::OPC_BRANCH, 6, 9, 0,
            3'd1, 7'h00, 32'h6);
    add_vec("c_slli", 1, 16'h019E, 16'h0, 32'h00719193, 0, rvc_pkg::OPC_IMM, 3, 3, 7,
            3'd1, 7'h00, 32'h7);
    add_vec("c_jr", 1, 16'h8282, 16'h0, 32'h00028067, 0, rvc_pkg::OPC_JALR, 0, 5, 0,
            3'd0, 7'h00, 32'h0);
    add_vec("c_jalr", 1, 16'h9302, 16'h0, 32'h000300E7, 0, rvc_pkg::OPC_JALR, 1, 6, 0,
            3'd0, 7'h00, 32'h0);
    add_vec("c_mv", 1, 16'h852E, 16'h0, 32'h00B00533, 0, rvc_pkg::OPC_OP, 10, 0, 11,
            3'd0, 7'h00, 32'h0);
    add_vec("c_add", 1, 16'h952E, 16'h0, 32'h00B50533, 0, rvc_pkg::OPC_OP, 10, 10, 11,
            3'd0, 7'h00, 32'h0);
    add_vec("addi_full", 2, 16'h0093, 16'hFFF1, 32'hFFF10093, 0, rvc_pkg::OPC_IMM, 1, 2, 31,
            3'd0, 7'h7F, 32'hFFFFFFFF);
    add_vec("zero_parcel", 1, 16'h0000, 16'h0, 32'h0, 1, 7'd0, 0, 0, 0,
            3'd0, 7'h00, 32'h0);
    add_vec("reserved_q0", 1, 16'h8000, 16'h0, 32'h0, 1, 7'd0, 0, 0, 0,
            3'd0, 7'h00, 32'h0);
    add_vec("unknown_full", 2, 16'h000F, 16'h0000, 32'h0, 1, 7'd0, 0, 0, 0,
            3'd0, 7'h00, 32'h0);
  endtask

  task automatic check_field(string test, string field, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s %s expected %h actual %h", test, field, exp, act);
      value_errors++;
    end
  endtask

  task automatic send_parcel(logic [15:0] p);
    @(negedge clk);
    parcel_valid = 1'b1;
    parcel       = p;
    parcel_count++;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      parcel_valid = 1'b0;
    end
  endtask

  task automatic send_instr(vec_t v, int gap);
    expect_t e;
    e.v  = v;
    e.pc = 32'(parcel_count * 2);  // Pc of the first parcel
    send_parcel(v.p0);
    if (v.n == 2) begin
      idle(gap);
      send_parcel(v.p1);
    end
    e.edge_n = edge_count + 1;
    expq.push_back(e);
    sent_count++;
    idle(gap);
  endtask

  task automatic wait_drain(int limit);
    int t;
    t = 0;
    while (expq.size() > 0 && t < limit) begin
      @(posedge clk);
      t++;
    end
    if (expq.size() > 0) begin
      $display("Timed out with %0d results still outstanding", expq.size());
      other_errors++;
      expq.delete();
    end
  endtask

  // Outputs change on the rising edge, so they are read on the falling one
  always @(negedge clk) begin
    expect_t e;
    if (arst_n && out.valid) begin
      out_count++;
      if (expq.size() == 0) begin
        $display("Output at pc %h arrived with no instruction outstanding", out.pc);
        other_errors++;
      end else begin
        e = expq.pop_front();
        check_field(e.v.name, "pc", e.pc, out.pc);
        check_field(e.v.name, "instr", e.v.instr, out.instr);
        check_field(e.v.name, "compressed", {31'd0, e.v.n == 1}, {31'd0, out.compressed});
        check_field(e.v.name, "illegal", {31'd0, e.v.illegal}, {31'd0, out.illegal});
        check_field(e.v.name, "op", {25'd0, e.v.op}, {25'd0, out.op});
        check_field(e.v.name, "rd", {27'd0, e.v.rd}, {27'd0, out.rd});
        check_field(e.v.name, "rs1", {27'd0, e.v.rs1}, {27'd0, out.rs1});
        check_field(e.v.name, "rs2", {27'd0, e.v.rs2}, {27'd0, out.rs2});
        check_field(e.v.name, "funct3", {29'd0, e.v.funct3}, {29'd0, out.funct3});
        check_field(e.v.name, "funct7", {25'd0, e.v.funct7}, {25'd0, out.funct7});
        check_field(e.v.name, "imm", e.v.imm, out.imm);
        // Three registers after the sampling edge
        check_field(e.v.name, "latency", 32'd2, 32'(edge_count - e.edge_n));
      end
    end
  end

  initial begin
    int idx;
    void'($urandom(19));
    clk          = 1'b0;
    arst_n       = 1'b0;
    parcel_valid = 1'b0;
    parcel       = '0;
    edge_count   = 0;
    parcel_count = 0;
    value_errors = 0;
    other_errors = 0;
    sent_count   = 0;
    out_count    = 0;
    build_table();
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    foreach (vecs[i]) send_instr(vecs[i], 2);
    wait_drain(20);

    foreach (vecs[i]) begin
      if (vecs[i].n == 1) send_instr(vecs[i], 0);  // One parcel per cycle
    end
    idle(1);
    wait_drain(20);

    repeat (40) begin
      idx = $urandom_range(vecs.size() - 1);
      send_instr(vecs[idx], $urandom_range(3));
    end
    idle(1);
    wait_drain(20);

    // Lower half of addi_full held when reset hits
    send_parcel(16'h0093);
    idle(1);
    arst_n       = 1'b0;
    parcel_count = 0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    send_instr(vecs[0], 1);
    wait_drain(20);
    idle(5);

    if (out_count != sent_count) begin
      $display("Saw %0d outputs for %0d instructions", out_count, sent_count);
      other_errors++;
    end
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #100000;
    $display("Simulation ran past its time limit");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/rvc_pkg.sv
logic/parcel_aligner.sv
logic/rvc_expander.sv
logic/instr_decoder.sv
logic/rv_frontend.sv
tests/rv_frontend_tb.sv

// ==== Makefile ====
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: obj_dir/Vrv_frontend_tb

obj_dir/Vrv_frontend_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module rv_frontend_tb \
		-f tb.f -o Vrv_frontend_tb

run: obj_dir/Vrv_frontend_tb
	./obj_dir/Vrv_frontend_tb | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
